// File: sim.f
source/trap_pkg.sv
source/trap_if.sv
source/trap_ctrl.sv
source/csr_file.sv
source/clint_timer.sv
source/trap_subsystem.sv
tb/tb_trap_subsystem.sv

// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = tb_trap_subsystem
FILELIST = sim.f
BUILD    = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: simulate clean

simulate:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: tb/tb_trap_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_trap_subsystem;
    import trap_pkg::*;

    // Cycle bound for each wait loop
    localparam int TIMEOUT = 200;

    logic                    sys_clk;
    logic                    sys_rst;
    logic                    ex_valid_i, ex_ecall_i, ex_ebreak_i, ex_illegal_i, ex_mret_i;
    logic                    mem_stall_i;
    logic [XLEN-1:0]         ex_pc_i;
    logic                    redirect_o;
    logic [XLEN-1:0]         redirect_pc_o;
    logic [CSR_ADDR_W-1:0]   csr_addr_i;
    csr_op_t                 csr_op_i;
    logic [XLEN-1:0]         csr_wdata_i, csr_rdata_o;
    logic                    clint_stb_i, clint_we_i, clint_ack_o, timer_irq_o;
    logic [CLINT_ADDR_W-1:0] clint_adr_i;
    logic [XLEN-1:0]         clint_wdata_i, clint_rdata_o;

    // Reference model state
    logic        m_mie, m_mpie, m_mtie, exp_irq;
    logic [1:0]  m_mpp, m_priv;
    logic [31:0] m_mtvec, m_mepc, m_mcause;
    logic [63:0] m_cmp, m_mtime_base;
    int          m_mtime_cyc, cyc, error_cnt, timeout_cnt;
    logic [CSR_ADDR_W-1:0] csr_list [6];
    logic [2:0]  flags;
    logic [31:0] pc;
    int          waited, c_rise;

    trap_subsystem trap_subsystem_inst (.*);

    always #50 sys_clk = ~sys_clk;

    // Edges counted from reset release for the mtime model
    always @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            error_cnt++;
        end
    endtask

    // mtime value right after edge c
    function automatic logic [63:0] mtime_at(input int c);
        return m_mtime_base + 64'(c - m_mtime_cyc);
    endfunction

    function automatic logic [31:0] model_csr(input logic [CSR_ADDR_W-1:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            CSR_MSTATUS: begin
                v[MSTATUS_MIE_BIT] = m_mie;
                v[MSTATUS_MPIE_BIT] = m_mpie;
                v[MSTATUS_MPP_LSB +: 2] = m_mpp;
            end
            CSR_MIE:    v[MIE_MTIE_BIT] = m_mtie;
            CSR_MTVEC:  v = m_mtvec;
            CSR_MEPC:   v = m_mepc;
            CSR_MCAUSE: v = m_mcause;
            // MTIP follows the timer line
            CSR_MIP:    v[MIE_MTIE_BIT] = exp_irq;
            default:    v = '0;
        endcase
        return v;
    endfunction

    task automatic model_csr_write(input logic [CSR_ADDR_W-1:0] addr, input csr_op_t op,
                                   input logic [31:0] wdata);
        logic [31:0] v;
        v = model_csr(addr);
        case (op)
            CSR_WRITE: v = wdata;
            CSR_SET:   v = v | wdata;
            CSR_CLEAR: v = v & ~wdata;
            default:   return;
        endcase
        case (addr)
            CSR_MSTATUS: begin
                m_mie = v[MSTATUS_MIE_BIT];
                m_mpie = v[MSTATUS_MPIE_BIT];
                // Reserved MPP encodings land on U
                m_mpp = (v[MSTATUS_MPP_LSB +: 2] == PRIV_M) ? PRIV_M : PRIV_U;
            end
            CSR_MIE:    m_mtie = v[MIE_MTIE_BIT];
            // Mode bit 1 not implemented
            CSR_MTVEC:  m_mtvec = {v[31:2], 1'b0, v[0]};
            CSR_MEPC:   m_mepc = {v[31:2], 2'b00};
            CSR_MCAUSE: m_mcause = v;
            default: begin
            end
        endcase
    endtask

    // Entered and left one step after a rising edge
    task automatic csr_access(input logic [CSR_ADDR_W-1:0] addr, input csr_op_t op,
                              input logic [31:0] wdata);
        csr_addr_i = addr;
        csr_op_i = op;
        csr_wdata_i = wdata;
        #1;
        // Read returns the value before the write
        check_value("csr_rdata_o", csr_rdata_o, model_csr(addr));
        model_csr_write(addr, op, wdata);
        @(posedge sys_clk);
        #1;
        csr_op_i = CSR_NONE;
    endtask

    task automatic read_trap_csrs();
        csr_access(CSR_MCAUSE, CSR_NONE, '0);
        csr_access(CSR_MEPC, CSR_NONE, '0);
        csr_access(CSR_MSTATUS, CSR_NONE, '0);
    endtask

    // One EX cycle with its redirect checked against the model
    task automatic ex_cycle(input logic valid, input logic ecall, input logic ebreak,
                            input logic illegal, input logic mret, input logic stall,
                            input logic [31:0] ex_pc);
        logic        exc, irq, trap, ret;
        logic [31:0] cause, target;
        ex_valid_i = valid;
        ex_ecall_i = ecall;
        ex_ebreak_i = ebreak;
        ex_illegal_i = illegal;
        ex_mret_i = mret;
        mem_stall_i = stall;
        ex_pc_i = ex_pc;
        exc = valid & (ecall | ebreak | illegal);
        // Interrupt only at a clean valid boundary
        irq = exp_irq & m_mtie & valid & ((m_priv == PRIV_U) | m_mie) & ~exc & ~stall;
        trap = (exc | irq) & ~stall;
        ret = valid & mret & ~stall & ~trap;
        if (irq)
            cause = INT_M_TIMER;
        else if (illegal)
            cause = EX_ILLEGAL_INST;
        else if (ecall)
            cause = (m_priv == PRIV_U) ? EX_ECALL_U : EX_ECALL_M;
        else
            cause = EX_BREAKPOINT;
        target = {m_mtvec[31:2], 2'b00};
        if (irq && m_mtvec[1:0] == MTVEC_MODE_VECTORED)
            target = target + {23'b0, cause[6:0], 2'b00};
        if (ret)
            target = m_mepc;
        #1;
        check_value("redirect_o", 32'(redirect_o), 32'(trap | ret));
        if (trap | ret)
            check_value("redirect_pc_o", redirect_pc_o, target);
        if (trap) begin
            m_mepc = {ex_pc[31:2], 2'b00};
            m_mcause = cause;
            m_mpie = m_mie;
            m_mie = 1'b0;
            m_mpp = m_priv;
            m_priv = PRIV_M;
        end else if (ret) begin
            m_mie = m_mpie;
            m_mpie = 1'b1;
            m_priv = m_mpp;
            m_mpp = PRIV_U;
        end
        @(posedge sys_clk);
        #1;
        {ex_valid_i, ex_ecall_i, ex_ebreak_i, ex_illegal_i, ex_mret_i, mem_stall_i} = '0;
    endtask

    // Bus cycle with stb held until the cycle after ack
    task automatic clint_access(input logic we, input logic [15:0] adr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output int acc_cyc);
        int n;
        clint_stb_i = 1'b1;
        clint_we_i = we;
        clint_adr_i = adr;
        clint_wdata_i = wdata;
        n = 0;
        while (!clint_ack_o && n < TIMEOUT) begin
            @(posedge sys_clk);
            #1;
            n++;
        end
        if (!clint_ack_o) begin
            $display("Timed out waiting for the timer bus ack at offset 0x%04h", adr);
            timeout_cnt++;
        end else if (n != 1) begin
            $display("Timer bus ack came after %0d cycles instead of one", n);
            error_cnt++;
        end
        // Ack rose at the accept edge
        acc_cyc = cyc;
        rdata = clint_rdata_o;
        @(posedge sys_clk);
        #1;
        clint_stb_i = 1'b0;
        if (clint_ack_o) begin
            $display("Timer bus gave a second ack for one access at offset 0x%04h", adr);
            error_cnt++;
        end
    endtask

    task automatic clint_write(input logic [15:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        logic [63:0] old;
        int          c;
        clint_access(1'b1, adr, data, unused, c);
        old = mtime_at(c - 1);
        case (adr)
            CLINT_MTIMECMP_LO: m_cmp[31:0] = data;
            CLINT_MTIMECMP_HI: m_cmp[63:32] = data;
            CLINT_MTIME_LO: begin
                m_mtime_base = {old[63:32], data};
                m_mtime_cyc = c;
            end
            CLINT_MTIME_HI: begin
                m_mtime_base = {data, old[31:0]};
                m_mtime_cyc = c;
            end
            default: begin
            end
        endcase
    endtask

    task automatic clint_read(input logic [15:0] adr);
        logic [31:0] got, exp;
        logic [63:0] t;
        int          c;
        clint_access(1'b0, adr, '0, got, c);
        // Data captured at the accept edge
        t = mtime_at(c - 1);
        case (adr)
            CLINT_MTIMECMP_LO: exp = m_cmp[31:0];
            CLINT_MTIMECMP_HI: exp = m_cmp[63:32];
            CLINT_MTIME_LO:    exp = t[31:0];
            CLINT_MTIME_HI:    exp = t[63:32];
            default:           exp = '0;
        endcase
        check_value("clint_rdata_o", got, exp);
    endtask

    initial begin
        void'($urandom(32'h383b_46de));
        csr_list = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MIP};
        sys_clk = 1'b0;
        sys_rst = 1'b1;
        {ex_valid_i, ex_ecall_i, ex_ebreak_i, ex_illegal_i, ex_mret_i, mem_stall_i} = '0;
        ex_pc_i = '0;
        csr_addr_i = '0;
        csr_op_i = CSR_NONE;
        csr_wdata_i = '0;
        clint_stb_i = 1'b0;
        clint_we_i = 1'b0;
        clint_adr_i = '0;
        clint_wdata_i = '0;
        error_cnt = 0;
        timeout_cnt = 0;
        // Reset values
        {m_mie, m_mpie, m_mtie, exp_irq} = '0;
        m_mpp = PRIV_U;
        m_priv = PRIV_M;
        m_mtvec = RESET_MTVEC;
        m_mepc = '0;
        m_mcause = '0;
        m_cmp = '1;
        repeat (3) @(posedge sys_clk);
        #1;
        sys_rst = 1'b0;
        m_mtime_base = '0;
        m_mtime_cyc = cyc;
        check_value("redirect_o", 32'(redirect_o), 32'd0);
        check_value("timer_irq_o", 32'(timer_irq_o), 32'd0);
        check_value("clint_ack_o", 32'(clint_ack_o), 32'd0);

        // Random CSR traffic with some unmapped addresses
        for (int i = 0; i < 40; i++) begin
            if ($urandom % 4 == 0)
                csr_access(12'h7c0 + 12'($urandom % 64), csr_op_t'(2'($urandom)), $urandom);
            else
                csr_access(csr_list[$urandom % 6], csr_op_t'(2'($urandom)), $urandom);
        end
        foreach (csr_list[i]) csr_access(csr_list[i], CSR_NONE, '0);

        // Timer bus with compare kept above mtime
        clint_read(CLINT_MTIME_LO);
        for (int i = 0; i < 4; i++) begin
            clint_write(CLINT_MTIME_LO, $urandom);
            clint_write(CLINT_MTIME_HI, $urandom % 32'hffff);
            clint_write(CLINT_MTIMECMP_LO, $urandom);
            clint_read(CLINT_MTIME_LO);
            clint_read(CLINT_MTIME_HI);
            clint_read(CLINT_MTIMECMP_LO);
            clint_read(CLINT_MTIMECMP_HI);
            clint_read(16'h0100);
            clint_read(CLINT_MTIME_LO);
        end

        // Exceptions from random flags and PCs
        for (int i = 0; i < 16; i++) begin
            csr_access(CSR_MSTATUS, CSR_WRITE, $urandom);
            flags = 3'($urandom);
            ex_cycle(($urandom % 4) != 0, flags[0], flags[1], flags[2], 1'b0, 1'b0, $urandom);
            read_trap_csrs();
        end

        // mret into U then ecall from U and from M
        csr_access(CSR_MSTATUS, CSR_CLEAR, 32'h3 << MSTATUS_MPP_LSB);
        csr_access(CSR_MEPC, CSR_WRITE, $urandom);
        ex_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, $urandom);
        csr_access(CSR_MSTATUS, CSR_NONE, '0);
        ex_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, $urandom);
        read_trap_csrs();
        ex_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, $urandom);
        read_trap_csrs();

        // Stall holds traps and mret
        for (int i = 0; i < 8; i++) begin
            flags = 3'(1 + $urandom % 7);
            pc = $urandom;
            ex_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, pc);
            read_trap_csrs();
            ex_cycle(1'b1, flags[0], flags[1], flags[2], 1'($urandom), 1'b1, pc);
            read_trap_csrs();
            ex_cycle(1'b1, flags[0], flags[1], flags[2], 1'b0, 1'b1, pc);
            ex_cycle(1'b1, flags[0], flags[1], flags[2], 1'b0, 1'b0, pc);
            read_trap_csrs();
        end

        // Timer interrupt in vectored mode
        csr_access(CSR_MIE, CSR_WRITE, 32'd1 << MIE_MTIE_BIT);
        csr_access(CSR_MTVEC, CSR_WRITE, ($urandom & 32'hffff_fffc) | 32'd1);
        csr_access(CSR_MSTATUS, CSR_CLEAR, 32'd1 << MSTATUS_MIE_BIT);
        clint_write(CLINT_MTIMECMP_LO, 32'h140);
        clint_write(CLINT_MTIME_HI, 32'h0);
        clint_write(CLINT_MTIME_LO, 32'h100);
        clint_write(CLINT_MTIMECMP_HI, 32'h0);
        c_rise = m_mtime_cyc + 1 + int'(m_cmp - m_mtime_base);
        waited = 0;
        while (!timer_irq_o && waited < TIMEOUT) begin
            @(posedge sys_clk);
            #1;
            waited++;
        end
        if (!timer_irq_o) begin
            $display("Timed out waiting for timer_irq_o to rise");
            timeout_cnt++;
        end else begin
            check_value("timer_irq_o rise cycle", cyc, c_rise);
        end
        exp_irq = 1'b1;
        csr_access(CSR_MIP, CSR_NONE, '0);
        // Masked in M while MIE is clear
        ex_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, $urandom);
        csr_access(CSR_MSTATUS, CSR_SET, 32'd1 << MSTATUS_MIE_BIT);
        ex_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, $urandom);
        read_trap_csrs();
        csr_access(CSR_MIE, CSR_WRITE, '0);

        $display("Checks done: %0d errors, %0d timeouts", error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/trap_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module trap_subsystem (
    input  logic                             sys_clk,
    input  logic                             sys_rst,
    // EX stage instruction and its trap flags
    input  logic                             ex_valid_i,
    input  logic [trap_pkg::XLEN-1:0]         ex_pc_i,
    input  logic                             ex_ecall_i,
    input  logic                             ex_ebreak_i,
    input  logic                             ex_illegal_i,
    input  logic                             ex_mret_i,
    input  logic                             mem_stall_i,
    // Fetch redirect
    output logic                             redirect_o,
    output logic [trap_pkg::XLEN-1:0]         redirect_pc_o,
    // CSR access from EX
    input  logic [trap_pkg::CSR_ADDR_W-1:0]   csr_addr_i,
    input  trap_pkg::csr_op_t                csr_op_i,
    input  logic [trap_pkg::XLEN-1:0]         csr_wdata_i,
    output logic [trap_pkg::XLEN-1:0]         csr_rdata_o,
    // Timer slave port
    input  logic                             clint_stb_i,
    input  logic                             clint_we_i,
    input  logic [trap_pkg::CLINT_ADDR_W-1:0] clint_adr_i,
    input  logic [trap_pkg::XLEN-1:0]         clint_wdata_i,
    output logic                             clint_ack_o,
    output logic [trap_pkg::XLEN-1:0]         clint_rdata_o,
    output logic                             timer_irq_o
);
    import trap_pkg::*;

    // Timer line, shared by MTIP and the controller
    logic timer_irq;

    trap_if trap_bus (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst)
    );

    trap_ctrl trap_ctrl_inst (
        .ex_valid_i    (ex_valid_i),
        .ex_pc_i       (ex_pc_i),
        .ex_ecall_i    (ex_ecall_i),
        .ex_ebreak_i   (ex_ebreak_i),
        .ex_illegal_i  (ex_illegal_i),
        .ex_mret_i     (ex_mret_i),
        .mem_stall_i   (mem_stall_i),
        .timer_irq_i   (timer_irq),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .tif           (trap_bus.ctrl)
    );

    csr_file csr_file_inst (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .csr_addr_i  (csr_addr_i),
        .csr_op_i    (csr_op_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .timer_irq_i (timer_irq),
        .tif         (trap_bus.csr)
    );

    clint_timer clint_timer_inst (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .clint_stb_i   (clint_stb_i),
        .clint_we_i    (clint_we_i),
        .clint_adr_i   (clint_adr_i),
        .clint_wdata_i (clint_wdata_i),
        .clint_ack_o   (clint_ack_o),
        .clint_rdata_o (clint_rdata_o),
        .timer_irq_o   (timer_irq)
    );

    // Also visible at the top for observation
    assign timer_irq_o = timer_irq;

endmodule

`default_nettype wire

// File: source/clint_timer.sv
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
    input  logic                             sys_clk,
    input  logic                             sys_rst,
    input  logic                             clint_stb_i,
    input  logic                             clint_we_i,
    input  logic [trap_pkg::CLINT_ADDR_W-1:0] clint_adr_i,
    input  logic [trap_pkg::XLEN-1:0]         clint_wdata_i,
    output logic                             clint_ack_o,
    output logic [trap_pkg::XLEN-1:0]         clint_rdata_o,
    output logic                             timer_irq_o
);
    import trap_pkg::*;

    logic [63:0]     mtime_q;
    logic [63:0]     mtimecmp_q;
    logic            ack_q;
    logic            irq_q;
    logic [XLEN-1:0] rdata_q;
    logic            accept;
    logic [XLEN-1:0] rd_mux;

    // New strobe only outside the ack cycle
    assign accept = clint_stb_i & ~ack_q;

    // 32-bit halves, unmapped offsets read zero
    always_comb begin
        case (clint_adr_i)
            CLINT_MTIMECMP_LO: rd_mux = mtimecmp_q[31:0];
            CLINT_MTIMECMP_HI: rd_mux = mtimecmp_q[63:32];
            CLINT_MTIME_LO:    rd_mux = mtime_q[31:0];
            CLINT_MTIME_HI:    rd_mux = mtime_q[63:32];
            default:           rd_mux = '0;
        endcase
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            ack_q      <= 1'b0;
            irq_q      <= 1'b0;
        end else begin
            ack_q <= accept;
            // Compare registered, so irq lags mtime by one cycle
            irq_q <= (mtime_q >= mtimecmp_q);
            // Free-running counter
            mtime_q <= mtime_q + 64'd1;
            // Bus writes win over the increment at the accept edge
            if (accept && clint_we_i) begin
                case (clint_adr_i)
                    CLINT_MTIMECMP_LO: mtimecmp_q[31:0] <= clint_wdata_i;
                    CLINT_MTIMECMP_HI: mtimecmp_q[63:32] <= clint_wdata_i;
                    // Other half keeps its current value
                    CLINT_MTIME_LO:    mtime_q <= {mtime_q[63:32], clint_wdata_i};
                    CLINT_MTIME_HI:    mtime_q <= {clint_wdata_i, mtime_q[31:0]};
                    default: begin
                    end
                endcase
            end
        end
    end

    // Read data captured with the request, held through ack
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            rdata_q <= rd_mux;
        end
    end

    assign clint_ack_o   = ack_q;
    assign clint_rdata_o = rdata_q;
    assign timer_irq_o   = irq_q;

    // Single-cycle ack even while the host keeps stb up
    a_ack_one_cycle : assert property (
        @(posedge sys_clk) disable iff (sys_rst)
        ack_q |=> !ack_q
    );

endmodule

`default_nettype wire

// File: source/csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module csr_file (
    input  logic                           sys_clk,
    input  logic                           sys_rst,
    input  logic [trap_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  trap_pkg::csr_op_t              csr_op_i,
    input  logic [trap_pkg::XLEN-1:0]       csr_wdata_i,
    output logic [trap_pkg::XLEN-1:0]       csr_rdata_o,
    input  logic                           timer_irq_i,
    trap_if.csr                            tif
);
    import trap_pkg::*;

    // mstatus kept as its three live fields
    logic            mstatus_mie_q;
    logic            mstatus_mpie_q;
    priv_t           mstatus_mpp_q;
    logic            mie_mtie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    priv_t           priv_q;

    // Read views and write path
    logic [XLEN-1:0] mstatus_rd;
    logic [XLEN-1:0] mie_rd;
    logic [XLEN-1:0] mip_rd;
    logic [XLEN-1:0] csr_old;
    logic [XLEN-1:0] csr_new;
    logic            csr_we;

    // Unsupported MPP encodings fall back to U
    function automatic priv_t legal_mpp(input logic [1:0] mpp);
        priv_t result;
        result = (mpp == PRIV_M) ? PRIV_M : PRIV_U;
        return result;
    endfunction

    // Assemble full-width views, other bits read zero
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[MSTATUS_MIE_BIT] = mstatus_mie_q;
        mstatus_rd[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
        mstatus_rd[MSTATUS_MPP_LSB +: 2] = mstatus_mpp_q;
        mie_rd = '0;
        mie_rd[MIE_MTIE_BIT] = mie_mtie_q;
        // MTIP mirrors the timer line directly
        mip_rd = '0;
        mip_rd[MIE_MTIE_BIT] = timer_irq_i;
    end

    // Read mux, unknown addresses give zero
    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS: csr_old = mstatus_rd;
            CSR_MIE:     csr_old = mie_rd;
            CSR_MTVEC:   csr_old = mtvec_q;
            CSR_MEPC:    csr_old = mepc_q;
            CSR_MCAUSE:  csr_old = mcause_q;
            CSR_MIP:     csr_old = mip_rd;
            default:     csr_old = '0;
        endcase
    end

    // Old value is returned, the update lands at the edge
    assign csr_rdata_o = csr_old;

    // Read-modify-write value
    always_comb begin
        case (csr_op_i)
            CSR_WRITE: csr_new = csr_wdata_i;
            CSR_SET:   csr_new = csr_old | csr_wdata_i;
            CSR_CLEAR: csr_new = csr_old & ~csr_wdata_i;
            default:   csr_new = csr_old;
        endcase
    end

    assign csr_we = (csr_op_i != CSR_NONE);

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mstatus_mpp_q  <= PRIV_U;
            mie_mtie_q     <= 1'b0;
            mtvec_q        <= RESET_MTVEC;
            mepc_q         <= '0;
            mcause_q       <= '0;
            priv_q         <= PRIV_M;
        end else if (tif.trap_enter) begin
            // Trap entry, any same-cycle CSR write is dropped
            mepc_q         <= {tif.trap_pc[XLEN-1:2], 2'b00};
            mcause_q       <= tif.trap_cause;
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
            mstatus_mpp_q  <= priv_q;
            priv_q         <= PRIV_M;
        end else if (tif.mret_exec) begin
            // Return restores interrupt enable and mode
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
            priv_q         <= mstatus_mpp_q;
            mstatus_mpp_q  <= PRIV_U;
        end else if (csr_we) begin
            case (csr_addr_i)
                CSR_MSTATUS: begin
                    mstatus_mie_q  <= csr_new[MSTATUS_MIE_BIT];
                    mstatus_mpie_q <= csr_new[MSTATUS_MPIE_BIT];
                    mstatus_mpp_q  <= legal_mpp(csr_new[MSTATUS_MPP_LSB +: 2]);
                end
                CSR_MIE: begin
                    mie_mtie_q <= csr_new[MIE_MTIE_BIT];
                end
                CSR_MTVEC: begin
                    // Only direct and vectored modes exist
                    mtvec_q <= {csr_new[XLEN-1:2], 1'b0, csr_new[0]};
                end
                CSR_MEPC: begin
                    mepc_q <= {csr_new[XLEN-1:2], 2'b00};
                end
                CSR_MCAUSE: begin
                    mcause_q <= csr_new;
                end
                // mip is read-only, the rest ignore writes
                default: begin
                end
            endcase
        end
    end

    // State for the trap controller
    assign tif.mtvec       = mtvec_q;
    assign tif.mepc        = mepc_q;
    assign tif.mie_mtie    = mie_mtie_q;
    assign tif.mstatus_mie = mstatus_mie_q;
    assign tif.priv        = priv_q;

    // Mode never leaves the implemented set, also across mret
    a_priv_legal : assert property (
        @(posedge sys_clk) disable iff (sys_rst)
        priv_q inside {PRIV_U, PRIV_M}
    );

endmodule

`default_nettype wire

// File: source/trap_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module trap_ctrl (
    input  logic                     ex_valid_i,
    input  logic [trap_pkg::XLEN-1:0] ex_pc_i,
    input  logic                     ex_ecall_i,
    input  logic                     ex_ebreak_i,
    input  logic                     ex_illegal_i,
    input  logic                     ex_mret_i,
    input  logic                     mem_stall_i,
    input  logic                     timer_irq_i,
    output logic                     redirect_o,
    output logic [trap_pkg::XLEN-1:0] redirect_pc_o,
    trap_if.ctrl                     tif
);
    import trap_pkg::*;

    logic            exc_present;
    logic            irq_enabled;
    logic            irq_take;
    logic            trap_take;
    logic            mret_take;
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] vec_base;
    logic [XLEN-1:0] vec_offset;
    logic [XLEN-1:0] trap_target;

    // Synchronous exceptions only count for a valid EX instruction
    assign exc_present = ex_valid_i & (ex_ecall_i | ex_ebreak_i | ex_illegal_i);

    // M interrupts are always enabled below M
    assign irq_enabled = (tif.priv == PRIV_U) | tif.mstatus_mie;

    // Interrupt waits for an instruction boundary with no exception
    assign irq_take = timer_irq_i & tif.mie_mtie & ex_valid_i & irq_enabled
                    & ~exc_present & ~mem_stall_i;

    // Stall holds everything, trap retried once it drops
    assign trap_take = (exc_present | irq_take) & ~mem_stall_i;

    // A trap in the same cycle wins over mret
    assign mret_take = ex_valid_i & ex_mret_i & ~mem_stall_i & ~trap_take;

    // Cause selection, interrupt first
    always_comb begin
        if (irq_take) begin
            cause = INT_M_TIMER;
        end else if (ex_illegal_i) begin
            cause = EX_ILLEGAL_INST;
        end else if (ex_ecall_i) begin
            // Code depends on the mode that issued the ecall
            cause = (tif.priv == PRIV_U) ? EX_ECALL_U : EX_ECALL_M;
        end else if (ex_ebreak_i) begin
            cause = EX_BREAKPOINT;
        end else begin
            cause = '0;
        end
    end

    // BASE field with the mode bits masked
    assign vec_base = {tif.mtvec[XLEN-1:2], 2'b00};

    // Four bytes per interrupt code
    assign vec_offset = {{(XLEN-9){1'b0}}, cause[6:0], 2'b00};

    // Vectoring applies to interrupts only
    always_comb begin
        if (irq_take && (tif.mtvec[1:0] == MTVEC_MODE_VECTORED)) begin
            trap_target = vec_base + vec_offset;
        end else begin
            trap_target = vec_base;
        end
    end

    // PC redirect, trap target or return address
    always_comb begin
        if (trap_take) begin
            redirect_o    = 1'b1;
            redirect_pc_o = trap_target;
        end else if (mret_take) begin
            redirect_o    = 1'b1;
            redirect_pc_o = tif.mepc;
        end else begin
            redirect_o    = 1'b0;
            redirect_pc_o = '0;
        end
    end

    // Events for the CSR file
    assign tif.trap_enter = trap_take;
    assign tif.trap_cause = cause;
    assign tif.trap_pc    = ex_pc_i;
    assign tif.mret_exec  = mret_take;

    // No flow change leaks out during a memory stall
    a_no_redirect_in_stall : assert property (
        @(posedge tif.sys_clk) disable iff (tif.sys_rst)
        mem_stall_i |-> !redirect_o
    );

    // CSR file must never see trap entry and return together
    a_trap_mret_exclusive : assert property (
        @(posedge tif.sys_clk) disable iff (tif.sys_rst)
        !(tif.trap_enter && tif.mret_exec)
    );

endmodule

`default_nettype wire

// File: source/trap_if.sv
`timescale 1ns/10ps
`default_nettype none

interface trap_if (
    input logic sys_clk,
    input logic sys_rst
);
    import trap_pkg::*;

    // Events from the trap controller
    logic            trap_enter;
    logic [XLEN-1:0] trap_cause;
    logic [XLEN-1:0] trap_pc;
    logic            mret_exec;

    // CSR state seen by the trap controller
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic            mie_mtie;
    logic            mstatus_mie;
    priv_t           priv;

    // Clock and reset are only for the controller's checks
    modport ctrl (
        input  sys_clk,
        input  sys_rst,
        output trap_enter,
        output trap_cause,
        output trap_pc,
        output mret_exec,
        input  mtvec,
        input  mepc,
        input  mie_mtie,
        input  mstatus_mie,
        input  priv
    );

    modport csr (
        input  trap_enter,
        input  trap_cause,
        input  trap_pc,
        input  mret_exec,
        output mtvec,
        output mepc,
        output mie_mtie,
        output mstatus_mie,
        output priv
    );

endinterface

`default_nettype wire

// File: source/trap_pkg.sv
`default_nettype none

package trap_pkg;

    // Datapath and address width
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // CSR access kind from the EX stage
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_t;

    // Only U and M are implemented
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_t;

    // Machine CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;

    // mstatus field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    // MPP occupies two bits from here
    localparam int MSTATUS_MPP_LSB  = 11;

    // Same position serves mie.MTIE and mip.MTIP
    localparam int MIE_MTIE_BIT = 7;

    // Exception codes
    localparam logic [XLEN-1:0] EX_ILLEGAL_INST = 32'd2;
    localparam logic [XLEN-1:0] EX_BREAKPOINT   = 32'd3;
    localparam logic [XLEN-1:0] EX_ECALL_U      = 32'd8;
    localparam logic [XLEN-1:0] EX_ECALL_M      = 32'd11;

    // Interrupt flag in the top bit, code 7
    localparam logic [XLEN-1:0] INT_M_TIMER = 32'h8000_0007;

    // mtvec.MODE encoding, direct is zero
    localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;

    // Timer slave address map, byte offsets
    localparam int CLINT_ADDR_W = 16;
    localparam logic [CLINT_ADDR_W-1:0] CLINT_MTIMECMP_LO = 16'h4000;
    localparam logic [CLINT_ADDR_W-1:0] CLINT_MTIMECMP_HI = 16'h4004;
    localparam logic [CLINT_ADDR_W-1:0] CLINT_MTIME_LO    = 16'hBFF8;
    localparam logic [CLINT_ADDR_W-1:0] CLINT_MTIME_HI    = 16'hBFFC;

    // Trap vector after reset
    localparam logic [XLEN-1:0] RESET_MTVEC = 32'h8000_0000;

endpackage

`default_nettype wire
